// File: aluPkg.sv
// Shared types, opcode classes and register map for the ALU cluster
// Byte addresses must be word aligned because byte selects are not supported
`default_nettype none

package aluPkg;

	localparam int numLanes = 4;

	////////////////////////////////////////
	// Opcode fields
	////////////////////////////////////////

	localparam logic [3:0] opClsFlagArith = 4'b0001; // Op[7:4], arithmetic that updates flags
	localparam logic [3:0] opClsJump      = 4'b0011; // Op[7:4], B passes through
	localparam int         opLdStBit      = 7;       // Set for load/store address generation

	////////////////////////////////////////
	// Register map, byte addresses
	////////////////////////////////////////

	// Lane i: A at base + 8i, B at base + 8i + 4
	localparam logic [7:0] adrOperandBase = 8'h00;
	// Opcode in [7:0], lane mask in [11:8]
	localparam logic [7:0] adrCmd         = 8'h20;
	localparam logic [7:0] adrResultBase  = 8'h40; // Lane i at base + 4i
	localparam logic [7:0] adrFlagsBase   = 8'h50; // Lane i at base + 4i, flags in [3:0]

	////////////////////////////////////////
	// Structs
	////////////////////////////////////////

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic o;
	} flags_t;

	typedef struct packed {
		logic [31:0] result;
		flags_t      flags;
		flags_t      en;     // One enable per flag
	} aluOut_t;

	typedef struct packed {
		logic [31:0] a;
		logic [31:0] b;
		logic [7:0]  op;
	} laneIn_t;

	typedef struct packed {
		logic [31:0] result;
		flags_t      flags;
	} laneOut_t;

	// Wishbone classic request, driven by the master
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [7:0]  adr;
		logic [31:0] dat;
	} wbReq_t;

endpackage

`default_nettype wire

// File: cpuAlu.sv
// Combinational ALU, unsigned multiply only, shift amounts taken from B[4:0]
// C and O are only meaningful for add and subtract, zero otherwise
`timescale 1ns/1ps
`default_nettype none

module cpuAlu (
	input  logic [31:0]     a,
	input  logic [31:0]     b,
	input  logic [7:0]      op,
	output aluPkg::aluOut_t y
);

	logic [32:0] sum;      // Extra bit holds the carry
	logic [32:0] diff;     // Extra bit holds the borrow
	logic [63:0] prod;
	logic [63:0] rotWide;
	logic [31:0] ldStRes;
	logic [31:0] arithRes;
	logic [31:0] shiftRes;
	logic [31:0] result;
	logic        isLdSt;
	logic        isJump;
	logic        isAdd;
	logic        isSub;
	logic        addOvf;
	logic        subOvf;

	////////////////////////////////////////
	// Datapath
	////////////////////////////////////////

	assign sum     = {1'b0, a} + {1'b0, b};
	assign diff    = {1'b0, a} - {1'b0, b};
	assign prod    = 64'(a) * 64'(b);
	assign rotWide = {a, a} >> b[4:0]; // Low word is A rotated right

	assign ldStRes = op[2] ? sum[31:0] : b; // Address = A + B, or B alone

	always_comb begin
		case (op[2:1])
			2'b00:   arithRes = sum[31:0];
			2'b01:   arithRes = diff[31:0];
			2'b10:   arithRes = prod[31:0];
			default: arithRes = prod[63:32]; // Multiply high
		endcase
	end

	always_comb begin
		case (op[2:1])
			2'b00:   shiftRes = a << b[4:0];
			2'b01:   shiftRes = a >> b[4:0];
			default: shiftRes = rotWide[31:0]; // 10 and 11 both rotate
		endcase
	end

	assign isLdSt = op[aluPkg::opLdStBit];
	assign isJump = (op[7:4] == aluPkg::opClsJump);

	// Load/store wins over the jump class, then Op[4] picks arith vs shift
	always_comb begin
		if (isLdSt)
			result = ldStRes;
		else if (isJump)
			result = b;
		else if (op[4])
			result = arithRes;
		else
			result = shiftRes;
	end

	////////////////////////////////////////
	// Flags
	////////////////////////////////////////

	assign isAdd = !isLdSt && !isJump && op[4] && (op[2:1] == 2'b00);
	assign isSub = !isLdSt && !isJump && op[4] && (op[2:1] == 2'b01);

	// Signed overflow
	assign addOvf = (a[31] == b[31]) && (sum[31] != a[31]);
	assign subOvf = (a[31] != b[31]) && (diff[31] != a[31]);

	assign y.result  = result;
	assign y.flags.n = result[31];
	assign y.flags.z = (result == 32'h0);
	assign y.flags.c = isAdd ? sum[32] : (isSub ? ~diff[32] : 1'b0); // No-borrow on sub
	assign y.flags.o = isAdd ? addOvf : (isSub ? subOvf : 1'b0);

	// Only the flag arithmetic class touches the flag register
	assign y.en = {4{op[7:4] == aluPkg::opClsFlagArith}};

endmodule

`default_nettype wire

// File: aluLane.sv
// One ALU lane, result and flags load on start when the lane is selected
// Flags without an enable keep their previous value
`timescale 1ns/1ps
`default_nettype none

module aluLane (
	input  logic             clk,
	input  logic             rstN,
	input  logic             start,
	input  logic             sel,
	input  aluPkg::laneIn_t  in,
	output aluPkg::laneOut_t out
);

	aluPkg::aluOut_t aluY;
	logic [31:0]     resultQ;
	aluPkg::flags_t  flagsQ;
	aluPkg::flags_t  flagsNext;

	cpuAlu uAlu (
		.a  (in.a),
		.b  (in.b),
		.op (in.op),
		.y  (aluY)
	);

	// Per-bit merge of new and held flags
	assign flagsNext = (aluY.flags & aluY.en) | (flagsQ & ~aluY.en);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			resultQ <= '0;
			flagsQ  <= '0;
		end else if (start && sel) begin
			resultQ <= aluY.result;
			flagsQ  <= flagsNext;
		end
	end

	assign out.result = resultQ;
	assign out.flags  = flagsQ;

endmodule

`default_nettype wire

// File: wbOperandRegs.sv
// Wishbone classic write side, no byte selects, no err or rty, single cycles only
// Operand and command registers are write only
`timescale 1ns/1ps
`default_nettype none

module wbOperandRegs (
	input  logic                        clk,
	input  logic                        rstN,
	input  aluPkg::wbReq_t              req,
	output logic                        ack,
	output aluPkg::laneIn_t             lanes [aluPkg::numLanes],
	output logic                        start,
	output logic [aluPkg::numLanes-1:0] laneMask
);

	logic                        ackQ;
	logic                        startQ;
	logic                        accept;
	logic                        cmdHit;
	logic                        opHit;
	logic [7:0]                  opOff;
	logic [7:0]                  opQ;
	logic [aluPkg::numLanes-1:0] maskQ;
	logic [31:0]                 aQ [aluPkg::numLanes];
	logic [31:0]                 bQ [aluPkg::numLanes];

	////////////////////////////////////////
	// Handshake and decode
	////////////////////////////////////////

	// A new access is taken once, ack follows one cycle later
	assign accept = req.cyc && req.stb && !ackQ;

	assign cmdHit = (req.adr == aluPkg::adrCmd);
	assign opOff  = req.adr - aluPkg::adrOperandBase;
	assign opHit  = (opOff < 8'(8 * aluPkg::numLanes)) && (opOff[1:0] == 2'b00);

	////////////////////////////////////////
	// Registers
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ackQ   <= 1'b0;
			startQ <= 1'b0;
			opQ    <= '0;
			maskQ  <= '0;
			for (int i = 0; i < aluPkg::numLanes; i++) begin
				aQ[i] <= '0;
				bQ[i] <= '0;
			end
		end else begin
			ackQ   <= accept;
			startQ <= accept && req.we && cmdHit; // High together with the command ack
			if (accept && req.we) begin
				if (cmdHit) begin
					opQ   <= req.dat[7:0];
					maskQ <= req.dat[8 +: aluPkg::numLanes];
				end
				for (int i = 0; i < aluPkg::numLanes; i++) begin
					if (opHit && (opOff[7:3] == i)) begin
						if (opOff[2])
							bQ[i] <= req.dat;
						else
							aQ[i] <= req.dat;
					end
				end
			end
		end
	end

	// Opcode is shared, operands are per lane
	always_comb begin
		for (int i = 0; i < aluPkg::numLanes; i++) begin
			lanes[i].a  = aQ[i];
			lanes[i].b  = bQ[i];
			lanes[i].op = opQ;
		end
	end

	assign ack      = ackQ;
	assign start    = startQ;
	assign laneMask = maskQ;

endmodule

`default_nettype wire

// File: laneReadMux.sv
// Wishbone read data, registered every cycle so it is valid during ack
// Unmapped addresses and the operand and command registers read as zero
`timescale 1ns/1ps
`default_nettype none

module laneReadMux (
	input  logic             clk,
	input  logic             rstN,
	input  logic [7:0]       adr,
	input  aluPkg::laneOut_t lanes [aluPkg::numLanes],
	output logic [31:0]      datR
);

	logic [31:0] datNext;
	logic [31:0] datQ;

	// Result and flags windows, one word per lane
	always_comb begin
		datNext = '0;
		for (int i = 0; i < aluPkg::numLanes; i++) begin
			if (adr == 8'(aluPkg::adrResultBase + 4 * i))
				datNext = lanes[i].result;
			if (adr == 8'(aluPkg::adrFlagsBase + 4 * i))
				datNext = {28'h0, lanes[i].flags}; // n z c o in [3:0]
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			datQ <= '0;
		else
			datQ <= datNext;
	end

	assign datR = datQ;

endmodule

`default_nettype wire

// File: aluCluster.sv
// Four-lane ALU cluster behind a Wishbone classic slave
// The master must hold its request until ack and drop stb afterwards
`timescale 1ns/1ps
`default_nettype none

module aluCluster (
	input  logic           clk,
	input  logic           rstN,
	input  aluPkg::wbReq_t req,
	output logic           ack,
	output logic [31:0]    datR
);

	aluPkg::laneIn_t             laneIn  [aluPkg::numLanes];
	aluPkg::laneOut_t            laneOut [aluPkg::numLanes];
	logic                        start;
	logic [aluPkg::numLanes-1:0] laneMask;

	wbOperandRegs uRegs (
		.clk      (clk),
		.rstN     (rstN),
		.req      (req),
		.ack      (ack),
		.lanes    (laneIn),
		.start    (start),
		.laneMask (laneMask)
	);

	// All lanes see the same start, the mask picks who updates
	for (genvar i = 0; i < aluPkg::numLanes; i++) begin : gLane
		aluLane uLane (
			.clk   (clk),
			.rstN  (rstN),
			.start (start),
			.sel   (laneMask[i]),
			.in    (laneIn[i]),
			.out   (laneOut[i])
		);
	end

	laneReadMux uMux (
		.clk   (clk),
		.rstN  (rstN),
		.adr   (req.adr),
		.lanes (laneOut),
		.datR  (datR)
	);

endmodule

`default_nettype wire

// File: tbClock.sv
// Free-running testbench clock with a 10 ns period
`timescale 1ns/1ps
`default_nettype none

module tbClock (
	output logic clk
);

	initial clk = 1'b0;

	always #5 clk = ~clk; // Half period

endmodule

`default_nettype wire

// File: tbAluCluster.sv
// ALU cluster testbench, bus driven on the falling edge, one access at a time
// Expected values come from a behavioral model of the opcode rules
`timescale 1ns/1ps
`default_nettype none

module tbAluCluster;

	localparam int ackTimeout = 16; // Cycles allowed per bus access

	logic           clk;
	logic           rstN;
	aluPkg::wbReq_t req;
	logic           ack;
	logic [31:0]    datR;
	logic [31:0]    opA      [aluPkg::numLanes];
	logic [31:0]    opB      [aluPkg::numLanes];
	logic [31:0]    expRes   [aluPkg::numLanes];
	logic [3:0]     expFlags [aluPkg::numLanes];
	logic [31:0]    edgeA    [4] = '{32'hffffffff, 32'h7fffffff, 32'h80000000, 32'h80000000};
	logic [31:0]    edgeB    [4] = '{32'h00000001, 32'h00000001, 32'h80000000, 32'h00000001};
	logic [7:0]     unmapped [6] = '{8'h00, 8'h04, 8'h20, 8'h42, 8'h60, 8'hfc};
	logic [7:0]     ldStOps  [4] = '{8'h80, 8'h84, 8'h30, 8'h3f};
	logic [3:0]     masks    [6] = '{4'h5, 4'ha, 4'h1, 4'h8, 4'h0, 4'he};
	int             errors   = 0;
	int             checks   = 0;
	int             testsOk  = 0;
	int             testsBad = 0;
	int             errMark  = 0;

	tbClock uClk (
		.clk (clk)
	);

	aluCluster uut (
		.clk  (clk),
		.rstN (rstN),
		.req  (req),
		.ack  (ack),
		.datR (datR)
	);

	////////////////////////////////////////
	// Bus protocol checks
	////////////////////////////////////////

	ackPulse: assert property (@(posedge clk) disable iff (!rstN) ack |=> !ack)
		else begin
			errors++;
			$display("Ack stayed high for more than one cycle at %0t", $time);
		end

	ackLatency: assert property (@(posedge clk) disable iff (!rstN)
			req.cyc && req.stb && !ack |=> ack)
		else begin
			errors++;
			$display("Ack did not follow the request by one cycle at %0t", $time);
		end

	////////////////////////////////////////
	// Model and bus tasks
	////////////////////////////////////////

	// Returns {result, n, z, c, o, flag enable}
	function automatic logic [36:0] refAlu(input logic [31:0] a, input logic [31:0] b,
			input logic [7:0] op);
		logic [31:0] r;
		logic        c;
		logic        o;
		logic [63:0] p;
		longint      s;
		c = 1'b0;
		o = 1'b0;
		p = {32'h0, a} * {32'h0, b};
		if (op[7])
			r = op[2] ? a + b : b;
		else if (op[7:4] == 4'h3)
			r = b;
		else if (op[4] && !op[2]) begin
			r = op[1] ? a - b : a + b;
			c = op[1] ? (a >= b) : (r < a); // Wrap on add means carry out
			s = op[1] ? longint'($signed(a)) - longint'($signed(b))
				: longint'($signed(a)) + longint'($signed(b));
			o = (s != longint'($signed(r)));
		end else if (op[4])
			r = op[1] ? p[63:32] : p[31:0];
		else if (!op[2])
			r = op[1] ? a >> b[4:0] : a << b[4:0];
		else
			r = (a >> b[4:0]) | (a << (32 - b[4:0]));
		return {r, r[31], r == 32'h0, c, o, op[7:4] == 4'h1};
	endfunction

	// One classic cycle, returns the read data seen with ack
	task automatic busCycle(input logic we, input logic [7:0] adr, input logic [31:0] dat,
			output logic [31:0] rd);
		int cycles;
		req = {1'b1, 1'b1, we, adr, dat}; // cyc stb we adr dat
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!ack && cycles < ackTimeout);
		if (ack) begin
			rd = datR;
			req = '0;
		end else begin
			$display("Timeout at %0t: no ack for address %h", $time, adr);
			$display("Verification failed");
			$finish;
		end
	endtask

	task automatic setOperands(input int i, input logic [31:0] a, input logic [31:0] b);
		logic [31:0] rd;
		busCycle(1'b1, aluPkg::adrOperandBase + 8'(8 * i), a, rd);
		busCycle(1'b1, aluPkg::adrOperandBase + 8'(8 * i + 4), b, rd);
		opA[i] = a;
		opB[i] = b;
	endtask

	task automatic runCmd(input logic [7:0] op, input logic [3:0] mask);
		logic [31:0] rd;
		logic [36:0] m;
		busCycle(1'b1, aluPkg::adrCmd, {20'h0, mask, op}, rd);
		for (int i = 0; i < aluPkg::numLanes; i++) begin
			m = refAlu(opA[i], opB[i], op);
			if (mask[i]) begin
				expRes[i] = m[36:5];
				if (m[0])
					expFlags[i] = m[4:1];
			end
		end
	endtask

	task automatic checkRead(input logic [7:0] adr, input logic [31:0] exp, input string name);
		logic [31:0] got;
		busCycle(1'b0, adr, 32'h0, got);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkLanes();
		for (int i = 0; i < aluPkg::numLanes; i++) begin
			checkRead(aluPkg::adrResultBase + 8'(4 * i), expRes[i],
				$sformatf("datR result lane %0d", i));
			checkRead(aluPkg::adrFlagsBase + 8'(4 * i), {28'h0, expFlags[i]},
				$sformatf("datR flags lane %0d", i));
		end
	endtask

	task automatic endTest(input int num, input string name);
		if (errors == errMark) begin
			testsOk++;
			$display("Test %0d %s: ok", num, name);
		end else begin
			testsBad++;
			$display("Test %0d %s: FAILED with %0d errors", num, name, errors - errMark);
		end
		errMark = errors;
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	initial begin
		void'($urandom(32'h4e828b6a));
		req = '0;
		rstN = 1'b0;
		for (int i = 0; i < aluPkg::numLanes; i++) begin
			opA[i] = '0;
			opB[i] = '0;
			expRes[i] = '0;
			expFlags[i] = '0;
		end
		repeat (8) @(negedge clk);
		rstN = 1'b1;

		setOperands(0, $urandom, $urandom); // Operand space still reads zero
		checkLanes();
		foreach (unmapped[k])
			checkRead(unmapped[k], 32'h0, $sformatf("datR unmapped %h", unmapped[k]));
		endTest(1, "reset and unmapped");

		// Two rounds of edge operands, then random ones
		for (int k = 0; k < 16; k++) begin
			for (int i = 0; i < aluPkg::numLanes; i++) begin
				if (k % 4 == 0)
					setOperands(i, edgeA[i], edgeB[i]);
				else if (k % 4 == 1)
					setOperands(i, edgeB[i], edgeA[i]);
				else
					setOperands(i, $urandom, $urandom);
			end
			runCmd(8'h10 + 8'(2 * (k / 4)), 4'hf);
			checkLanes();
		end
		endTest(2, "arithmetic and flags");

		for (int k = 0; k < 4 * 32; k++) begin
			for (int i = 0; i < aluPkg::numLanes; i++)
				setOperands(i, $urandom, ($urandom & 32'hffffffe0) | 32'((k + 8 * i) % 32));
			runCmd(8'(2 * (k / 32)), 4'hf); // 00 02 04 06
			checkLanes();
		end
		endTest(3, "shift and rotate");

		for (int k = 0; k < 8; k++) begin
			for (int i = 0; i < aluPkg::numLanes; i++)
				setOperands(i, $urandom, $urandom);
			runCmd((k < 4) ? ldStOps[k] : (8'h80 | 8'($urandom)), 4'hf);
			checkLanes();
		end
		endTest(4, "load/store and jump");

		foreach (masks[k]) begin
			for (int i = 0; i < aluPkg::numLanes; i++)
				setOperands(i, $urandom, $urandom);
			runCmd(8'h10 + 8'(2 * (k % 4)), masks[k]);
			checkLanes();
		end
		endTest(5, "lane mask");

		for (int i = 0; i < aluPkg::numLanes; i++)
			setOperands(i, $urandom, $urandom);
		for (int k = 0; k < 12; k++) begin
			if (k == 6)
				setOperands(1, $urandom, $urandom);
			runCmd(8'($urandom), 4'($urandom));
		end
		checkLanes();
		// Operand, command and lane words all hold data now
		foreach (unmapped[k])
			checkRead(unmapped[k], 32'h0, $sformatf("datR unmapped %h", unmapped[k]));
		endTest(6, "back-to-back commands");

		$display("Summary: %0d tests ok, %0d tests failed, %0d reads checked, %0d errors",
			testsOk, testsBad, checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
aluPkg.sv
cpuAlu.sv
aluLane.sv
wbOperandRegs.sv
laneReadMux.sv
aluCluster.sv
tbClock.sv
tbAluCluster.sv
